//--- dramItf.f
padIfPkg.sv
glbIfPkg.sv
portArbiter.sv
sipoPacker.sv
pisoSplitter.sv
offChipItf.sv
tbOffChipItf.sv

//--- glbIfPkg.sv
`default_nettype none

// ==================================================
// On-chip global buffer definitions
// ==================================================
package glbIfPkg;

    // GLB word and address widths
    localparam int SRAM_WIDTH = 128;
    localparam int ADDR_WIDTH = 16;

    // Port map
    // Write ports come first, read ports follow
    localparam int NUM_WRPORT     = 3;
    localparam int NUM_RDPORT     = 2;
    localparam int NUM_PORT       = NUM_WRPORT + NUM_RDPORT;
    localparam int PORT_IDX_WIDTH = $clog2(NUM_PORT);

    // One GLB word
    typedef struct packed {
        logic [SRAM_WIDTH-1:0] data;
        logic                  last;
    } glbWord_t;

    // Transfer states
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        IN,
        OUT,
        FNH
    } itfState_e;

endpackage

`default_nettype wire

//--- offChipItf.sv
`timescale 1ns/1ps
`default_nettype none

module offChipItf
    import padIfPkg::*, glbIfPkg::*;
(
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    // Pad out, command then read data
    output padBeat_t                                  padOut,
    output logic                                      padOutVld,
    input  wire logic                                 padOutRdy,
    // Pad in, write data
    input  wire padBeat_t                             padIn,
    input  wire logic                                 padInVld,
    output logic                                      padInRdy,
    // Per-port side inputs
    input  wire logic [NUM_PORT-1:0]                  glbUrgent,
    input  wire logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  glbReqNum,
    input  wire logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  glbAddr,
    input  wire logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  baseAddr,
    // GLB write ports
    output glbWord_t                                  glbWrWord,
    output logic [NUM_WRPORT-1:0]                     glbWrVld,
    input  wire logic [NUM_WRPORT-1:0]                glbWrRdy,
    // GLB read ports
    input  wire glbWord_t [NUM_RDPORT-1:0]            glbRdWord,
    input  wire logic [NUM_RDPORT-1:0]                glbRdVld,
    output logic [NUM_RDPORT-1:0]                     glbRdRdy
);

    itfState_e                 state;
    itfState_e                 nextState;
    logic [PORT_IDX_WIDTH-1:0] selPort;
    logic [PORT_IDX_WIDTH-1:0] arbPort;
    logic                      reqAny;
    logic                      rdGlb;
    logic                      rdTaken;   // last read word already pulled
    padCmd_t                   cmd;
    // Packer links
    logic                      packInVld;
    logic                      packInRdy;
    glbWord_t                  packWord;
    logic                      packVld;
    logic                      packRdy;
    logic                      wrRdySel;
    // Splitter links
    glbWord_t                  rdWordSel;
    logic                      rdVldSel;
    logic                      splitInVld;
    logic                      splitInRdy;
    padBeat_t                  splitBeat;
    logic                      splitVld;
    logic                      splitRdy;

    // ==================================================
    // Transfer FSM
    // ==================================================
    always_comb begin
        nextState = state;
        case (state)
            IDLE: if (reqAny) nextState = CMD;
            CMD:  if (padOutRdy) nextState = rdGlb ? OUT : IN;
            // Last packed word taken by the write port
            IN:   if (packVld && packRdy && packWord.last) nextState = FNH;
            // Last pad beat taken by the far side
            OUT:  if (splitVld && splitRdy && splitBeat.last) nextState = FNH;
            FNH:  nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            selPort <= '0;
            rdTaken <= 1'b0;
        end else begin
            state <= nextState;
            // Port is latched once per transfer
            if (state == IDLE && reqAny) begin
                selPort <= arbPort;
            end
            if (state == CMD) begin
                rdTaken <= 1'b0;
            end else if (splitInVld && splitInRdy && rdWordSel.last) begin
                rdTaken <= 1'b1;
            end
        end
    end

    portArbiter portArbiter_inst (
        .urgent (glbUrgent),
        .reqNum (glbReqNum),
        .reqAny (reqAny),
        .port   (arbPort)
    );

    // ==================================================
    // Command beat
    // ==================================================
    assign rdGlb      = (selPort >= PORT_IDX_WIDTH'(NUM_WRPORT));
    assign cmd.zero   = '0;
    assign cmd.reqNum = glbReqNum[selPort];
    assign cmd.addr   = baseAddr[selPort] + glbAddr[selPort];   // wraps at 2^16
    assign cmd.rdGlb  = rdGlb;

    // Pad out mux
    always_comb begin
        if (state == CMD) begin
            padOut.data = cmd;
            padOut.last = 1'b1;
            padOutVld   = 1'b1;
        end else begin
            padOut    = splitBeat;
            padOutVld = splitVld & (state == OUT);
        end
    end

    // ==================================================
    // Write path, pad to GLB
    // ==================================================
    assign padInRdy  = packInRdy & (state == IN);
    assign packInVld = padInVld & (state == IN);

    // Ready from the selected write port
    always_comb begin
        wrRdySel = 1'b0;
        for (int i = 0; i < NUM_WRPORT; i++) begin
            if (selPort == PORT_IDX_WIDTH'(i)) wrRdySel = glbWrRdy[i];
        end
    end

    assign packRdy   = wrRdySel & (state == IN);
    assign glbWrWord = packWord;

    // Valid only towards the selected write port
    always_comb begin
        for (int i = 0; i < NUM_WRPORT; i++) begin
            glbWrVld[i] = packVld & (state == IN) & (selPort == PORT_IDX_WIDTH'(i));
        end
    end

    sipoPacker sipoPacker_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .inBeat (padIn),
        .inVld  (packInVld),
        .inRdy  (packInRdy),
        .outWord(packWord),
        .outVld (packVld),
        .outRdy (packRdy)
    );

    // ==================================================
    // Read path, GLB to pad
    // ==================================================
    always_comb begin
        rdWordSel = glbRdWord[0];
        rdVldSel  = 1'b0;
        for (int i = 0; i < NUM_RDPORT; i++) begin
            if (selPort == PORT_IDX_WIDTH'(NUM_WRPORT + i)) begin
                rdWordSel = glbRdWord[i];
                rdVldSel  = glbRdVld[i];
            end
        end
    end

    // No more words once the last one is in
    assign splitInVld = rdVldSel & (state == OUT) & ~rdTaken;
    assign splitRdy   = padOutRdy & (state == OUT);

    // Ready only towards the selected read port
    always_comb begin
        for (int i = 0; i < NUM_RDPORT; i++) begin
            glbRdRdy[i] = splitInRdy & (state == OUT) & ~rdTaken
                        & (selPort == PORT_IDX_WIDTH'(NUM_WRPORT + i));
        end
    end

    pisoSplitter pisoSplitter_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .inWord (rdWordSel),
        .inVld  (splitInVld),
        .inRdy  (splitInRdy),
        .outBeat(splitBeat),
        .outVld (splitVld),
        .outRdy (splitRdy)
    );

endmodule

`default_nettype wire

//--- padIfPkg.sv
`default_nettype none

// ==================================================
// Off-chip pad bus definitions
// ==================================================
package padIfPkg;

    // Width of one pad beat
    localparam int PAD_WIDTH = 64;

    // Command field widths
    localparam int CMD_FIELD_WIDTH = 16;
    localparam int CMD_ZERO_WIDTH  = PAD_WIDTH - 2 * CMD_FIELD_WIDTH - 1;

    // One pad transfer unit
    typedef struct packed {
        logic [PAD_WIDTH-1:0] data;
        logic                 last;
    } padBeat_t;

    // Command beat, exactly one pad beat wide
    // MSB side is zero fill, LSB is the direction flag
    typedef struct packed {
        logic [CMD_ZERO_WIDTH-1:0]  zero;
        logic [CMD_FIELD_WIDTH-1:0] reqNum;
        logic [CMD_FIELD_WIDTH-1:0] addr;
        logic                       rdGlb;   // 1 = GLB read, data goes off-chip
    } padCmd_t;

endpackage

`default_nettype wire

//--- pisoSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module pisoSplitter
    import padIfPkg::*, glbIfPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    // GLB side
    input  wire glbWord_t inWord,
    input  wire logic     inVld,
    output logic          inRdy,
    // Pad side
    output padBeat_t      outBeat,
    output logic          outVld,
    input  wire logic     outRdy
);

    logic                  full;
    logic                  hi;        // 1 = high half is current
    logic [SRAM_WIDTH-1:0] wordData;
    logic                  wordLast;
    logic                  inFire;
    logic                  outFire;

    assign outFire = outVld & outRdy;
    // Empty, or the high half leaves on this edge
    assign inRdy   = ~full | (hi & outRdy);
    assign inFire  = inVld & inRdy;

    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            hi   <= 1'b0;
        end else begin
            if (outFire) begin
                hi <= ~hi;
                if (hi) begin
                    full <= 1'b0;
                end
            end
            // New word overrides the drain above
            if (inFire) begin
                full <= 1'b1;
                hi   <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (inFire) begin
            wordData <= inWord.data;
            wordLast <= inWord.last;
        end
    end

    // Low half first, last flag only on the high half
    assign outBeat.data = hi ? wordData[SRAM_WIDTH-1:PAD_WIDTH] : wordData[PAD_WIDTH-1:0];
    assign outBeat.last = hi & wordLast;
    assign outVld       = full;

endmodule

`default_nettype wire

//--- portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter
    import glbIfPkg::*;
(
    input  wire logic [NUM_PORT-1:0]                 urgent,
    input  wire logic [NUM_PORT-1:0][ADDR_WIDTH-1:0] reqNum,
    output logic                                     reqAny,
    output logic [PORT_IDX_WIDTH-1:0]                port
);

    logic                      urgAny;
    logic [PORT_IDX_WIDTH-1:0] urgIdx;
    logic [PORT_IDX_WIDTH-1:0] maxIdx;
    logic [ADDR_WIDTH-1:0]     maxNum;

    // ==================================================
    // Urgent flags
    // ==================================================
    // Scan high to low so the lowest index is written last
    always_comb begin
        urgAny = 1'b0;
        urgIdx = '0;
        for (int i = NUM_PORT - 1; i >= 0; i--) begin
            if (urgent[i]) begin
                urgAny = 1'b1;
                urgIdx = PORT_IDX_WIDTH'(i);
            end
        end
    end

    // ==================================================
    // Largest pending count
    // ==================================================
    // Strict compare keeps the lowest index on ties
    always_comb begin
        maxNum = reqNum[0];
        maxIdx = '0;
        for (int i = 1; i < NUM_PORT; i++) begin
            if (reqNum[i] > maxNum) begin
                maxNum = reqNum[i];
                maxIdx = PORT_IDX_WIDTH'(i);
            end
        end
    end

    // Urgent wins over count
    assign port   = urgAny ? urgIdx : maxIdx;
    // Any flag or any non-zero count is work to do
    assign reqAny = urgAny | (maxNum != '0);

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tbOffChipItf -f dramItf.f -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- sipoPacker.sv
`timescale 1ns/1ps
`default_nettype none

module sipoPacker
    import padIfPkg::*, glbIfPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    // Pad side
    input  wire padBeat_t inBeat,
    input  wire logic     inVld,
    output logic          inRdy,
    // GLB side
    output glbWord_t      outWord,
    output logic          outVld,
    input  wire logic     outRdy
);

    logic                  half;      // 0 = next beat is low half
    logic                  full;
    logic [SRAM_WIDTH-1:0] wordData;
    logic                  wordLast;
    logic                  inFire;
    logic                  outFire;

    // Stall input while a finished word waits
    assign inRdy   = ~full;
    assign inFire  = inVld & inRdy;
    assign outFire = outVld & outRdy;

    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half <= 1'b0;
            full <= 1'b0;
        end else begin
            if (inFire) begin
                half <= ~half;
            end
            // Second beat completes the word
            if (inFire && half) begin
                full <= 1'b1;
            end else if (outFire) begin
                full <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (inFire && !half) begin
            wordData[PAD_WIDTH-1:0] <= inBeat.data;
        end
        if (inFire && half) begin
            wordData[SRAM_WIDTH-1:PAD_WIDTH] <= inBeat.data;
            wordLast <= inBeat.last;   // last of the second beat only
        end
    end

    assign outWord.data = wordData;
    assign outWord.last = wordLast;
    assign outVld       = full;

endmodule

`default_nettype wire

//--- tbOffChipItf.sv
`timescale 1ns/1ps
`default_nettype none

module tbOffChipItf
    import padIfPkg::*, glbIfPkg::*;
();

    // Beats per test including command beats
    localparam int IDLE_BEATS  = 10;
    localparam int URG_BEATS   = 5;
    localparam int CNT_BEATS   = 19;
    localparam int WR_BEATS    = 9;
    localparam int RD_BEATS    = 7;
    localparam int BP_BEATS    = 26;
    localparam int B2B_BEATS   = 12;
    localparam int TIMEOUT_CYCLES = (IDLE_BEATS + URG_BEATS + CNT_BEATS + WR_BEATS + RD_BEATS
                                   + BP_BEATS + B2B_BEATS) * 8 + 200;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    padBeat_t                             padOut;
    logic                                 padOutVld;
    logic                                 padOutRdy = 1'b0;
    padBeat_t                             padIn = '0;
    logic                                 padInVld = 1'b0;
    logic                                 padInRdy;
    logic [NUM_PORT-1:0]                  glbUrgent;
    logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  glbReqNum;
    logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  glbAddr;
    logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  baseAddr;
    glbWord_t                             glbWrWord;
    logic [NUM_WRPORT-1:0]                glbWrVld;
    logic [NUM_WRPORT-1:0]                glbWrRdy = '0;
    glbWord_t [NUM_RDPORT-1:0]            glbRdWord = '0;
    logic [NUM_RDPORT-1:0]                glbRdVld = '0;
    logic [NUM_RDPORT-1:0]                glbRdRdy;

    // Scoreboards and models
    padBeat_t              padExpQ[$];
    bit                    padExpCmd[$];
    glbWord_t              wrExpQ[$];
    padBeat_t              padInQ[$];
    glbWord_t              rdQ[NUM_RDPORT][$];

    int                    dataSeed = 32'hc094c81c;
    int                    rdySeed  = 32'hc094c81c;
    logic [31:0]           rnd;
    logic                  stall = 1'b0;
    logic                  idleCheck = 1'b0;
    logic [NUM_WRPORT-1:0] wrMask = '0;
    logic [NUM_RDPORT-1:0] rdMask = '0;
    string                 testName = "reset";
    int                    errCount = 0;
    int                    portErrs = 0;
    int                    checkCount = 0;
    int                    cmdSeen = 0;
    int                    testCount = 0;
    int                    startErrs;
    int                    cycleCount = 0;

    // Monitor locals
    padBeat_t              expBeat;
    bit                    expIsCmd;
    glbWord_t              expWord;
    logic                  padStall = 1'b0;
    padBeat_t              prevPadOut;
    logic                  wrStall = 1'b0;
    logic [NUM_WRPORT-1:0] prevWrVld;
    glbWord_t              prevWrWord;

    offChipItf offChipItf_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .padOut    (padOut),
        .padOutVld (padOutVld),
        .padOutRdy (padOutRdy),
        .padIn     (padIn),
        .padInVld  (padInVld),
        .padInRdy  (padInRdy),
        .glbUrgent (glbUrgent),
        .glbReqNum (glbReqNum),
        .glbAddr   (glbAddr),
        .baseAddr  (baseAddr),
        .glbWrWord (glbWrWord),
        .glbWrVld  (glbWrVld),
        .glbWrRdy  (glbWrRdy),
        .glbRdWord (glbRdWord),
        .glbRdVld  (glbRdVld),
        .glbRdRdy  (glbRdRdy)
    );

    always #50 clk = ~clk;

    // ==================================================
    // Expected values and scoreboard fill
    // ==================================================
    // Command beat from zero fill, count, wrapped address and read flag
    function automatic logic [PAD_WIDTH-1:0] cmdBits(input int p, input logic [15:0] num,
                                                     input logic [15:0] addr,
                                                     input logic [15:0] base);
        logic [15:0] sum;
        logic        rd;
        sum = base + addr;
        rd  = (p >= NUM_WRPORT);
        return {31'b0, num, sum, rd};
    endfunction

    // Only the chosen port may see valid or ready
    task automatic setMask(input int p);
        wrMask = '0;
        rdMask = '0;
        if (p < NUM_WRPORT) wrMask[p] = 1'b1;
        else rdMask[p - NUM_WRPORT] = 1'b1;
    endtask

    task automatic pushCmd(input int p);
        padBeat_t b;
        b.data = cmdBits(p, glbReqNum[p], glbAddr[p], baseAddr[p]);
        b.last = 1'b1;
        padExpQ.push_back(b);
        padExpCmd.push_back(1'b1);
    endtask

    // Two pad beats per GLB word with the low half first
    task automatic pushWrite(input int words);
        logic [PAD_WIDTH-1:0] lo;
        logic [PAD_WIDTH-1:0] hi;
        padBeat_t             b;
        glbWord_t             w;
        for (int i = 0; i < words; i++) begin
            lo = {$random(dataSeed), $random(dataSeed)};
            hi = {$random(dataSeed), $random(dataSeed)};
            b.data = lo;
            b.last = 1'b0;
            padInQ.push_back(b);
            b.data = hi;
            b.last = (i == words - 1);
            padInQ.push_back(b);
            w.data = {hi, lo};
            w.last = (i == words - 1);
            wrExpQ.push_back(w);
        end
    endtask

    // Read word leaves as two beats with last only on the final high half
    task automatic pushRead(input int p, input int words);
        glbWord_t w;
        padBeat_t b;
        for (int i = 0; i < words; i++) begin
            w.data = {$random(dataSeed), $random(dataSeed), $random(dataSeed), $random(dataSeed)};
            w.last = (i == words - 1);
            rdQ[p - NUM_WRPORT].push_back(w);
            b.data = w.data[PAD_WIDTH-1:0];
            b.last = 1'b0;
            padExpQ.push_back(b);
            padExpCmd.push_back(1'b0);
            b.data = w.data[SRAM_WIDTH-1:PAD_WIDTH];
            b.last = w.last;
            padExpQ.push_back(b);
            padExpCmd.push_back(1'b0);
        end
    endtask

    task automatic waitCmds(input int n);
        while (cmdSeen < n) @(negedge clk);
    endtask

    task automatic waitDrain();
        while (padExpQ.size() != 0 || wrExpQ.size() != 0 || padInQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic clearReqs();
        glbUrgent = '0;
        glbReqNum = '0;
    endtask

    // One full transfer on port p with side inputs already set
    task automatic serve(input int p, input int words);
        int target;
        target = cmdSeen + 1;
        setMask(p);
        pushCmd(p);
        if (p < NUM_WRPORT) pushWrite(words);
        else pushRead(p, words);
        waitCmds(target);
        @(negedge clk);
        clearReqs();
        waitDrain();
    endtask

    task automatic startTest(input string name);
        testName  = name;
        startErrs = errCount + portErrs;
    endtask

    task automatic endTest();
        testCount++;
        $display("Test %s done, %0d error(s)", testName, errCount + portErrs - startErrs);
    endtask

    // ==================================================
    // Drivers on the falling edge
    // ==================================================
    always @(negedge clk) begin
        rnd       = $random(rdySeed);
        padOutRdy = stall ? rnd[0] : 1'b1;
        glbWrRdy  = stall ? rnd[3:1] : '1;
        // Valid stays up once raised and the front only moves on a transfer
        padInVld  = (padInQ.size() != 0) && (padInVld || !stall || rnd[4]);
        if (padInQ.size() != 0) padIn = padInQ[0];
        for (int i = 0; i < NUM_RDPORT; i++) begin
            glbRdVld[i] = (rdQ[i].size() != 0) && (glbRdVld[i] || !stall || rnd[5 + i]);
            if (rdQ[i].size() != 0) glbRdWord[i] = rdQ[i][0];
        end
    end

    // ==================================================
    // Checks on the rising edge
    // ==================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        ((glbWrVld & ~wrMask) == '0) && ((glbRdRdy & ~rdMask) == '0))
    else begin
        portErrs++;
        $display("A GLB port that was not selected saw valid or ready in test %s", testName);
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (idleCheck) begin
                checkCount++;
                assert (!padOutVld && !padInRdy && glbWrVld == '0 && glbRdRdy == '0) else begin
                    errCount++;
                    $display("Handshake outputs active with no request in test %s", testName);
                end
            end
            // Held valid keeps its data
            if (padStall) begin
                assert (padOutVld && padOut == prevPadOut) else begin
                    errCount++;
                    $display("Pad out changed before its transfer in test %s", testName);
                end
            end
            if (wrStall) begin
                assert (glbWrVld == prevWrVld && glbWrWord == prevWrWord) else begin
                    errCount++;
                    $display("GLB write changed before its transfer in test %s", testName);
                end
            end
            padStall   = padOutVld && !padOutRdy;
            prevPadOut = padOut;
            wrStall    = (glbWrVld & ~glbWrRdy) != '0;
            prevWrVld  = glbWrVld;
            prevWrWord = glbWrWord;
            // Pad out scoreboard with commands and read beats in order
            if (padOutVld && padOutRdy) begin
                assert (padExpQ.size() != 0) else begin
                    errCount++;
                    $display("Pad beat sent with none expected in test %s", testName);
                end
                if (padExpQ.size() != 0) begin
                    expBeat  = padExpQ.pop_front();
                    expIsCmd = padExpCmd.pop_front();
                    if (expIsCmd) cmdSeen++;
                    checkCount++;
                    assert (padOut == expBeat) else begin
                        errCount++;
                        $display("Error %s: expected %h, actual %h", testName, expBeat, padOut);
                    end
                end
            end
            // GLB write scoreboard
            if ((glbWrVld & glbWrRdy) != '0) begin
                assert (wrExpQ.size() != 0) else begin
                    errCount++;
                    $display("GLB word written with none expected in test %s", testName);
                end
                if (wrExpQ.size() != 0) begin
                    expWord = wrExpQ.pop_front();
                    checkCount++;
                    assert (glbWrWord == expWord) else begin
                        errCount++;
                        $display("Error %s: expected %h, actual %h", testName, expWord, glbWrWord);
                    end
                end
            end
            // Model side consumption
            if (padInVld && padInRdy) void'(padInQ.pop_front());
            for (int i = 0; i < NUM_RDPORT; i++) begin
                if (glbRdVld[i] && glbRdRdy[i]) void'(rdQ[i].pop_front());
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        rst_n     = 1'b0;
        glbUrgent = '0;
        glbReqNum = '0;
        glbAddr   = '0;
        baseAddr  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        startTest("idle");
        idleCheck = 1'b1;
        repeat (IDLE_BEATS) @(negedge clk);
        idleCheck = 1'b0;
        endTest();

        // Urgent on 4 and 1 so port 1 wins and the address wraps
        startTest("urgent");
        glbUrgent    = 5'b10010;
        glbReqNum[1] = 16'd2;
        glbReqNum[4] = 16'd7;
        glbAddr[1]   = 16'h0f00;
        baseAddr[1]  = 16'hf800;
        glbAddr[4]   = 16'h0040;
        serve(1, 2);
        endTest();

        // Counts 5 9 9 2 0 where the tie goes to port 1
        startTest("count");
        glbReqNum[0] = 16'd5;
        glbReqNum[1] = 16'd9;
        glbReqNum[2] = 16'd9;
        glbReqNum[3] = 16'd2;
        glbAddr[1]   = 16'h1234;
        baseAddr[1]  = 16'h0100;
        serve(1, 9);
        endTest();

        startTest("write");
        glbReqNum[2] = 16'd4;
        glbAddr[2]   = 16'h0a00;
        baseAddr[2]  = 16'h2000;
        serve(2, 4);
        endTest();

        startTest("read");
        glbUrgent[4] = 1'b1;
        glbReqNum[4] = 16'd3;
        baseAddr[4]  = 16'hfff0;
        serve(4, 3);
        endTest();

        // Random ready and valid gaps on every stream
        startTest("backpressure");
        stall        = 1'b1;
        glbReqNum[0] = 16'd6;
        glbAddr[0]   = 16'h0300;
        serve(0, 6);
        glbReqNum[3] = 16'd6;
        glbAddr[3]   = 16'h0500;
        serve(3, 6);
        stall = 1'b0;
        endTest();

        // Port 3 stays pending while port 0 runs
        startTest("backtoback");
        glbReqNum[0] = 16'd3;
        glbReqNum[3] = 16'd2;
        wrMask       = 3'b001;
        rdMask       = 2'b01;
        pushCmd(0);
        pushWrite(3);
        pushCmd(3);
        pushRead(3, 2);
        waitCmds(cmdSeen + 1);
        @(negedge clk);
        glbReqNum[0] = '0;
        waitCmds(cmdSeen + 1);
        @(negedge clk);
        clearReqs();
        waitDrain();
        endTest();

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount,
                 errCount + portErrs);
        if (errCount + portErrs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
